// ==== hw/ooo_settings.svh ====
`ifndef OOO_SETTINGS_SVH
`define OOO_SETTINGS_SVH

// Number of reservation station slots
`define RS_DEPTH 8

// Renamed destination tag width
`define TAG_WIDTH 5

// Datapath width
`define XLEN 32

// Multiplier pipeline stages
`define MULT_LATENCY 3

`endif

// ==== hw/isa_pkg.sv ====
package isa_pkg;

    typedef enum logic {
        OP_R = 1'b0,  // Second operand from a register
        OP_I = 1'b1   // Second operand is the immediate
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5,
        ALU_MUL = 3'd6
    } alu_op_t;

    typedef struct packed {
        opcode_t     fmt;
        alu_op_t     op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [12:0] unused;
    } r_format_t;

    typedef struct packed {
        opcode_t     fmt;
        alu_op_t     op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [1:0]  unused;
        logic [15:0] imm;  // Signed
    } i_format_t;

    typedef union packed {
        r_format_t r;
        i_format_t i;
    } instr_u;

endpackage

// ==== hw/ooo_pkg.sv ====
`include "ooo_settings.svh"

package ooo_pkg;

    import isa_pkg::*;

    typedef logic [`TAG_WIDTH-1:0] tag_t;
    typedef logic [`XLEN-1:0] word_t;

    // Free slot count, 0 to RS_DEPTH
    typedef logic [$clog2(`RS_DEPTH+1)-1:0] count_t;

    typedef struct packed {
        logic  ready;
        tag_t  tag;    // Producer tag while not ready
        word_t value;
    } operand_t;

    typedef struct packed {
        logic     valid;
        alu_op_t  op;
        tag_t     dest;
        operand_t src1;
        operand_t src2;
    } rs_entry_t;

    typedef enum logic {
        UNIT_ALU  = 1'b0,
        UNIT_MULT = 1'b1
    } unit_t;

    function automatic unit_t unit_of(alu_op_t op);
        unit_t unit;
        unit = (op == ALU_MUL) ? UNIT_MULT : UNIT_ALU;
        return unit;
    endfunction

endpackage

// ==== hw/dispatch_decode.sv ====
`timescale 1ns/1ps

`include "ooo_settings.svh"

module dispatch_decode
    import isa_pkg::*;
    import ooo_pkg::*;
(
    input  logic      dispatch,
    input  instr_u    instr,
    input  tag_t      dest_tag,

    input  logic      src1_ready,
    input  tag_t      src1_tag,
    input  word_t     src1_value,
    input  logic      src2_ready,
    input  tag_t      src2_tag,
    input  word_t     src2_value,

    output logic      entry_valid,
    output rs_entry_t entry
);
    word_t imm_ext;

    assign imm_ext = {{(`XLEN-16){instr.i.imm[15]}}, instr.i.imm};

    always_comb begin
        entry.valid = dispatch;
        entry.op    = instr.r.op;  // Same position in both formats
        entry.dest  = dest_tag;

        entry.src1.ready = src1_ready;
        entry.src1.tag   = src1_tag;
        entry.src1.value = src1_value;

        if (instr.r.fmt == OP_I) begin
            entry.src2.ready = 1'b1;  // Immediate needs no wakeup
            entry.src2.tag   = '0;
            entry.src2.value = imm_ext;
        end else begin
            entry.src2.ready = src2_ready;
            entry.src2.tag   = src2_tag;
            entry.src2.value = src2_value;
        end
    end

    assign entry_valid = dispatch;

    // Op code 7 has no meaning
    always_comb begin
        if (dispatch) begin
            op_known: assert #0 (instr.r.op inside
                {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_MUL});
        end
    end

endmodule

// ==== hw/reservation_station.sv ====
`timescale 1ns/1ps

`include "ooo_settings.svh"

module reservation_station
    import ooo_pkg::*;
(
    input  logic      clock,
    input  logic      reset,

    input  logic      entry_valid,
    input  rs_entry_t entry,
    input  logic      alu_busy,

    input  logic      cdb_valid,
    input  tag_t      cdb_tag,
    input  word_t     cdb_value,

    output logic      alu_issue_valid,
    output rs_entry_t alu_issue_entry,
    output logic      mult_issue_valid,
    output rs_entry_t mult_issue_entry,
    output logic      full,
    output count_t    open_entries
);
    localparam int IDX_W = $clog2(`RS_DEPTH);

    rs_entry_t entries      [`RS_DEPTH];
    rs_entry_t next_entries [`RS_DEPTH];

    logic [IDX_W-1:0] alu_idx;
    logic [IDX_W-1:0] mult_idx;
    logic [IDX_W-1:0] free_idx;
    logic             alu_found;
    logic             mult_found;
    logic             dup_tag;

    function automatic operand_t wake(operand_t src, logic bus_valid, tag_t bus_tag,
                                      word_t bus_value);
        operand_t result;
        result = src;
        if (!src.ready && bus_valid && src.tag == bus_tag) begin
            result.ready = 1'b1;
            result.value = bus_value;
        end
        return result;
    endfunction

    // Lowest ready entry per unit and lowest free slot
    always_comb begin
        alu_idx      = '0;
        mult_idx     = '0;
        free_idx     = '0;
        alu_found    = 1'b0;
        mult_found   = 1'b0;
        open_entries = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (entries[i].valid && entries[i].src1.ready && entries[i].src2.ready) begin
                if (unit_of(entries[i].op) == UNIT_MULT) begin
                    mult_idx   = IDX_W'(i);
                    mult_found = 1'b1;
                end else begin
                    alu_idx   = IDX_W'(i);
                    alu_found = 1'b1;
                end
            end
            if (!entries[i].valid) begin
                free_idx     = IDX_W'(i);
                open_entries = open_entries + 1'b1;
            end
        end
    end

    assign full             = (open_entries == '0);
    assign alu_issue_valid  = alu_found && !alu_busy;
    assign alu_issue_entry  = entries[alu_idx];
    assign mult_issue_valid = mult_found;
    assign mult_issue_entry = entries[mult_idx];

    always_comb begin
        next_entries = entries;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            next_entries[i].src1 = wake(entries[i].src1, cdb_valid, cdb_tag, cdb_value);
            next_entries[i].src2 = wake(entries[i].src2, cdb_valid, cdb_tag, cdb_value);
        end
        if (alu_issue_valid) begin
            next_entries[alu_idx].valid = 1'b0;
        end
        if (mult_issue_valid) begin
            next_entries[mult_idx].valid = 1'b0;
        end
        if (entry_valid && !full) begin
            next_entries[free_idx]      = entry;
            next_entries[free_idx].src1 = wake(entry.src1, cdb_valid, cdb_tag, cdb_value);
            next_entries[free_idx].src2 = wake(entry.src2, cdb_valid, cdb_tag, cdb_value);
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (reset) begin
                entries[i].valid <= 1'b0;
            end else begin
                entries[i] <= next_entries[i];
            end
        end
    end

    always_comb begin
        dup_tag = 1'b0;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            for (int j = i + 1; j < `RS_DEPTH; j++) begin
                if (entries[i].valid && entries[j].valid && entries[i].dest == entries[j].dest)
                    dup_tag = 1'b1;
            end
        end
    end

    no_dispatch_when_full: assert property (@(posedge clock) disable iff (reset)
        !(entry_valid && full));

    unique_dest_tags: assert property (@(posedge clock) disable iff (reset) !dup_tag);

endmodule

// ==== hw/exec_units.sv ====
`timescale 1ns/1ps

`include "ooo_settings.svh"

module exec_units
    import isa_pkg::*;
    import ooo_pkg::*;
(
    input  logic      clock,
    input  logic      reset,

    input  logic      alu_issue_valid,
    input  rs_entry_t alu_issue_entry,
    input  logic      mult_issue_valid,
    input  rs_entry_t mult_issue_entry,
    input  logic      alu_taken,

    output logic      alu_busy,
    output logic      alu_done,
    output tag_t      alu_tag,
    output word_t     alu_value,
    output logic      mult_done,
    output tag_t      mult_tag,
    output word_t     mult_value
);
    word_t alu_a;
    word_t alu_b;
    word_t alu_result;

    logic  mult_valid_q [`MULT_LATENCY];
    tag_t  mult_tag_q   [`MULT_LATENCY];
    word_t mult_value_q [`MULT_LATENCY];

    assign alu_a = alu_issue_entry.src1.value;
    assign alu_b = alu_issue_entry.src2.value;

    always_comb begin
        case (alu_issue_entry.op)
            ALU_ADD: alu_result = alu_a + alu_b;
            ALU_SUB: alu_result = alu_a - alu_b;
            ALU_AND: alu_result = alu_a & alu_b;
            ALU_OR:  alu_result = alu_a | alu_b;
            ALU_XOR: alu_result = alu_a ^ alu_b;
            ALU_SLT: alu_result = word_t'($signed(alu_a) < $signed(alu_b));
            default: alu_result = '0;
        endcase
    end

    // Holding register until the bus takes it
    always_ff @(posedge clock) begin
        if (reset) begin
            alu_done <= 1'b0;
        end else if (alu_issue_valid) begin
            alu_done <= 1'b1;
        end else if (alu_taken) begin
            alu_done <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (alu_issue_valid) begin
            alu_tag   <= alu_issue_entry.dest;
            alu_value <= alu_result;
        end
    end

    assign alu_busy = alu_done && !alu_taken;

    // Multiplier never stalls
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < `MULT_LATENCY; s++)
                mult_valid_q[s] <= 1'b0;
        end else begin
            mult_valid_q[0] <= mult_issue_valid;
            for (int s = 1; s < `MULT_LATENCY; s++)
                mult_valid_q[s] <= mult_valid_q[s-1];
        end
    end

    always_ff @(posedge clock) begin
        mult_tag_q[0]   <= mult_issue_entry.dest;
        mult_value_q[0] <= mult_issue_entry.src1.value * mult_issue_entry.src2.value;  // Low half
        for (int s = 1; s < `MULT_LATENCY; s++) begin
            mult_tag_q[s]   <= mult_tag_q[s-1];
            mult_value_q[s] <= mult_value_q[s-1];
        end
    end

    assign mult_done  = mult_valid_q[`MULT_LATENCY-1];
    assign mult_tag   = mult_tag_q[`MULT_LATENCY-1];
    assign mult_value = mult_value_q[`MULT_LATENCY-1];

    no_alu_issue_when_busy: assert property (@(posedge clock) disable iff (reset)
        alu_issue_valid |-> !alu_busy);

endmodule

// ==== hw/result_bus.sv ====
`timescale 1ns/1ps

`include "ooo_settings.svh"

module result_bus
    import ooo_pkg::*;
(
    input  logic  alu_done,
    input  tag_t  alu_tag,
    input  word_t alu_value,
    input  logic  mult_done,
    input  tag_t  mult_tag,
    input  word_t mult_value,

    output logic  alu_taken,
    output logic  cdb_valid,
    output tag_t  cdb_tag,
    output word_t cdb_value
);
    // Multiplier first since its pipeline cannot hold a result
    always_comb begin
        alu_taken = 1'b0;
        cdb_valid = 1'b0;
        cdb_tag   = alu_tag;
        cdb_value = alu_value;
        if (mult_done) begin
            cdb_valid = 1'b1;
            cdb_tag   = mult_tag;
            cdb_value = mult_value;
        end else if (alu_done) begin
            cdb_valid = 1'b1;
            alu_taken = 1'b1;  // Frees the holding register
        end
    end

endmodule

// ==== hw/issue_core.sv ====
`timescale 1ns/1ps

`include "ooo_settings.svh"

module issue_core
    import isa_pkg::*;
    import ooo_pkg::*;
(
    input  logic   clock,
    input  logic   reset,

    input  logic   dispatch,
    input  instr_u instr,
    input  tag_t   dest_tag,
    input  logic   src1_ready,
    input  tag_t   src1_tag,
    input  word_t  src1_value,
    input  logic   src2_ready,
    input  tag_t   src2_tag,
    input  word_t  src2_value,

    output logic   full,
    output count_t open_entries,
    output logic   cdb_valid,
    output tag_t   cdb_tag,
    output word_t  cdb_value
);
    logic      entry_valid;
    rs_entry_t entry;
    logic      alu_issue_valid;
    rs_entry_t alu_issue_entry;
    logic      mult_issue_valid;
    rs_entry_t mult_issue_entry;
    logic      alu_busy;
    logic      alu_taken;
    logic      alu_done;
    tag_t      alu_tag;
    word_t     alu_value;
    logic      mult_done;
    tag_t      mult_tag;
    word_t     mult_value;

    dispatch_decode i_decode (
        .dispatch, .instr, .dest_tag,
        .src1_ready, .src1_tag, .src1_value,
        .src2_ready, .src2_tag, .src2_value,
        .entry_valid, .entry
    );

    reservation_station i_station (
        .clock, .reset, .entry_valid, .entry, .alu_busy,
        .cdb_valid, .cdb_tag, .cdb_value,
        .alu_issue_valid, .alu_issue_entry, .mult_issue_valid, .mult_issue_entry,
        .full, .open_entries
    );

    exec_units i_exec (
        .clock, .reset,
        .alu_issue_valid, .alu_issue_entry, .mult_issue_valid, .mult_issue_entry,
        .alu_taken, .alu_busy,
        .alu_done, .alu_tag, .alu_value,
        .mult_done, .mult_tag, .mult_value
    );

    result_bus i_result (
        .alu_done, .alu_tag, .alu_value,
        .mult_done, .mult_tag, .mult_value,
        .alu_taken, .cdb_valid, .cdb_tag, .cdb_value
    );

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD       = 100.0,
    parameter int  RESET_CYCLES = 10
) (
    output logic clock,
    output logic reset
);
    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2.0) clock = ~clock;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

// ==== test/issue_core_tb.sv ====
`timescale 1ns/1ps

`include "ooo_settings.svh"

module issue_core_tb
    import isa_pkg::*;
    import ooo_pkg::*;
();
    localparam real CLOCK_PERIOD = 100.0;
    localparam int  RESET_CYCLES = 10;
    localparam int  NUM_TESTS    = 5;
    localparam int  TEST_CYCLES  = 200;
    localparam int  NUM_TAGS     = 1 << `TAG_WIDTH;

    logic   clock;
    logic   reset;
    logic   dispatch;
    instr_u instr;
    tag_t   dest_tag;
    logic   src1_ready;
    tag_t   src1_tag;
    word_t  src1_value;
    logic   src2_ready;
    tag_t   src2_tag;
    word_t  src2_value;
    logic   full;
    count_t open_entries;
    logic   cdb_valid;
    tag_t   cdb_tag;
    word_t  cdb_value;

    word_t model_value [NUM_TAGS];  // Expected result per tag
    logic  pending     [NUM_TAGS];
    tag_t  free_tags   [$];
    int    in_flight;               // Dispatched and not yet broadcast
    int    full_cycles;
    logic  exact_count;
    logic  expect_pending;
    word_t expect_value;
    string test_name;
    int    errors;
    int    errors_before;
    int    tests_failed;

    tb_clock #(.PERIOD(CLOCK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) i_clock (.clock, .reset);

    issue_core i_dut (
        .clock, .reset, .dispatch, .instr, .dest_tag,
        .src1_ready, .src1_tag, .src1_value,
        .src2_ready, .src2_tag, .src2_value,
        .full, .open_entries, .cdb_valid, .cdb_tag, .cdb_value
    );

    always @(posedge clock) begin
        if (reset) begin
            in_flight   <= 0;
            full_cycles <= 0;
            for (int i = 0; i < NUM_TAGS; i++)
                pending[i] <= 1'b0;
        end else begin
            in_flight <= in_flight + int'(dispatch) - int'(cdb_valid);
            if (dispatch) begin
                pending[dest_tag] <= 1'b1;
            end
            if (cdb_valid) begin
                pending[cdb_tag] <= 1'b0;
                free_tags.push_back(cdb_tag);  // Tag back to the free list
            end
            if (full) begin
                full_cycles <= full_cycles + 1;
            end
        end
    end

    assign expect_pending = pending[cdb_tag];
    assign expect_value   = model_value[cdb_tag];

    cdb_tag_pending: assert property (@(posedge clock) disable iff (reset)
        cdb_valid |-> expect_pending)
        else begin
            $display("tag %0d broadcast in test %s with no op waiting for it",
                     $sampled(cdb_tag), test_name);
            errors++;
        end

    cdb_value_correct: assert property (@(posedge clock) disable iff (reset)
        cdb_valid |-> cdb_value == expect_value)
        else begin
            $display("FAILED %s: tag %0d expected %h actual %h", test_name,
                     $sampled(cdb_tag), $sampled(expect_value), $sampled(cdb_value));
            errors++;
        end

    full_matches_count: assert property (@(posedge clock) disable iff (reset)
        exact_count |-> full == (in_flight == `RS_DEPTH))
        else begin
            $display("FAILED %s: full expected %b actual %b", test_name,
                     $sampled(in_flight == `RS_DEPTH), $sampled(full));
            errors++;
        end

    station_within_flight: assert property (@(posedge clock) disable iff (reset)
        int'(open_entries) + in_flight >= `RS_DEPTH)
        else begin
            $display("station in test %s holds more entries than are in flight", test_name);
            errors++;
        end

    empty_when_idle: assert property (@(posedge clock) disable iff (reset)
        in_flight == 0 |-> int'(open_entries) == `RS_DEPTH && !full)
        else begin
            $display("FAILED %s: open_entries/full expected %0d/0 actual %0d/%b", test_name,
                     `RS_DEPTH, $sampled(open_entries), $sampled(full));
            errors++;
        end

    occupancy_exact: assert property (@(posedge clock) disable iff (reset)
        exact_count |-> int'(open_entries) == `RS_DEPTH - in_flight)
        else begin
            $display("FAILED %s: open_entries expected %0d actual %0d", test_name,
                     `RS_DEPTH - $sampled(in_flight), $sampled(open_entries));
            errors++;
        end

    function automatic word_t expected_result(alu_op_t op, word_t a, word_t b);
        logic [2*`XLEN-1:0] product;
        logic               less;
        product = (2*`XLEN)'(a) * (2*`XLEN)'(b);
        less    = (a[`XLEN-1] != b[`XLEN-1]) ? a[`XLEN-1] : (a < b);  // Signed compare
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a + ~b + 1'b1;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLT: return word_t'(less);
            ALU_MUL: return product[`XLEN-1:0];
            default: return 'x;
        endcase
    endfunction

    task automatic reserve_tag(output tag_t tag);
        while (free_tags.size() == 0) begin
            @(posedge clock);
            dispatch <= 1'b0;
        end
        tag = free_tags.pop_front();
    endtask

    task automatic dispatch_op(input alu_op_t op, input logic use_imm, input logic [15:0] imm,
                               input logic wait1, input tag_t tag1, input word_t val1,
                               input logic wait2, input tag_t tag2, input word_t val2,
                               input tag_t dest);
        word_t  a;
        word_t  b;
        instr_u word;
        a    = wait1 ? model_value[tag1] : val1;
        b    = wait2 ? model_value[tag2] : val2;
        word = '0;
        if (use_imm) begin
            word.i.fmt = OP_I;
            word.i.op  = op;
            word.i.imm = imm;
            b = word_t'(int'($signed(imm)));
        end else begin
            word.r.fmt = OP_R;
            word.r.op  = op;
        end
        model_value[dest] = expected_result(op, a, b);
        @(posedge clock);
        dispatch   <= 1'b1;
        instr      <= word;
        dest_tag   <= dest;
        src1_ready <= !wait1;
        src1_tag   <= tag1;
        src1_value <= val1;
        src2_ready <= !wait2;
        src2_tag   <= tag2;
        src2_value <= val2;
    endtask

    task automatic send_ready(input alu_op_t op, input word_t a, input word_t b,
                              output tag_t dest);
        reserve_tag(dest);
        dispatch_op(op, 1'b0, '0, 1'b0, '0, a, 1'b0, '0, b, dest);
    endtask

    task automatic send_imm(input alu_op_t op, input word_t a, input logic [15:0] imm,
                            output tag_t dest);
        reserve_tag(dest);
        dispatch_op(op, 1'b1, imm, 1'b0, '0, a, 1'b0, '0, $urandom, dest);  // Junk src2
    endtask

    task automatic send_after(input alu_op_t op, input tag_t producer, input word_t b,
                              output tag_t dest);
        reserve_tag(dest);
        dispatch_op(op, 1'b0, '0, 1'b1, producer, $urandom, 1'b0, '0, b, dest);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clock);
            dispatch <= 1'b0;
        end
    endtask

    task automatic drain();
        idle(2);  // Last dispatch counted first
        while (in_flight != 0)
            @(posedge clock);
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        errors_before = errors;
    endtask

    task automatic report_test();
        if (errors == errors_before) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, errors - errors_before);
            tests_failed++;
        end
    endtask

    initial begin
        tag_t  p;
        tag_t  c;
        tag_t  blocker;
        word_t x;
        word_t y;
        int    full_before;
        void'($urandom(25090));
        dispatch     = 1'b0;
        instr        = '0;
        dest_tag     = '0;
        src1_ready   = 1'b0;
        src1_tag     = '0;
        src1_value   = '0;
        src2_ready   = 1'b0;
        src2_tag     = '0;
        src2_value   = '0;
        exact_count  = 1'b0;
        errors       = 0;
        tests_failed = 0;
        for (int i = 0; i < NUM_TAGS; i++) begin
            free_tags.push_back(tag_t'(i));
            model_value[i] = '0;
        end
        @(negedge reset);

        start_test("alu_r_ops");
        for (int op = 0; op < 6; op++) begin
            repeat (3) begin
                send_ready(alu_op_t'(op), $urandom, $urandom, p);
            end
            send_ready(alu_op_t'(op), 32'h8000_0000, 32'h7fff_ffff, p);  // Sign corner
        end
        drain();
        report_test();

        start_test("imm_ops");
        repeat (14) begin
            send_imm(alu_op_t'($urandom_range(0, 6)), $urandom, 16'($urandom), p);
            idle($urandom_range(0, 1));
        end
        drain();
        report_test();

        start_test("mul_mix");
        repeat (20) begin
            if ($urandom_range(0, 1) == 1) begin
                send_ready(ALU_MUL, $urandom, $urandom, p);
            end else begin
                send_ready(alu_op_t'($urandom_range(0, 5)), $urandom, $urandom, p);
            end
            idle($urandom_range(0, 1));
        end
        drain();
        report_test();

        start_test("dep_chains");
        for (int gap = 0; gap < 2; gap++) begin
            repeat (3) begin
                send_ready(alu_op_t'($urandom_range(0, 5)), $urandom, $urandom, p);
                idle(gap);  // Gap of one wakes in the dispatch cycle
                send_after(alu_op_t'($urandom_range(0, 6)), p, $urandom, c);
                drain();
            end
        end
        send_ready(ALU_MUL, $urandom, $urandom, p);
        repeat (6) begin
            send_after(alu_op_t'($urandom_range(0, 6)), p, $urandom, c);
            p = c;
        end
        drain();
        report_test();

        start_test("fill_station");
        reserve_tag(blocker);
        x = $urandom;
        y = $urandom;
        model_value[blocker] = expected_result(ALU_ADD, x, y);
        full_before = full_cycles;
        exact_count <= 1'b1;
        repeat (`RS_DEPTH - 1) begin
            send_after(alu_op_t'($urandom_range(0, 6)), blocker, $urandom, c);
        end
        dispatch_op(ALU_ADD, 1'b0, '0, 1'b0, '0, x, 1'b0, '0, y, blocker);
        idle(1);
        @(posedge clock);
        exact_count <= 1'b0;  // Blocker leaves on this edge
        drain();
        station_filled: assert (full_cycles > full_before)
            else begin
                $display("station never reported full in test %s", test_name);
                errors++;
            end
        report_test();

        $display("%0d tests, %0d passed, %0d failed, %0d errors", NUM_TESTS,
                 NUM_TESTS - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #(CLOCK_PERIOD * (NUM_TESTS * TEST_CYCLES + RESET_CYCLES));
        $display("timeout in test %s, %0d results never broadcast", test_name, in_flight);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+hw
hw/isa_pkg.sv
hw/ooo_pkg.sv
hw/dispatch_decode.sv
hw/reservation_station.sv
hw/exec_units.sv
hw/result_bus.sv
hw/issue_core.sv
test/tb_clock.sv
test/issue_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f files.f --top-module issue_core_tb -Mdir "$build_dir" -o issue_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator compilation failed"
    exit 1
fi

"./$build_dir/issue_core_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF '*** FAILED ***' "$log"; then
    exit 1
fi
exit 0
